// File: list.f
design/sound_regs_pkg.sv
design/sound_gen_pkg.sv
design/sound_io_regs.sv
design/tone_osc.sv
design/noise_gen.sv
design/sound_mixer.sv
design/sound_io_top.sv
dv/tb_clock_gen.sv
dv/sound_io_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the sound peripheral testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sound_io_tb -f list.f -o sim_sound_io
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out="$(./obj_dir/sim_sound_io)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

// File: dv/sound_io_tb.sv
`timescale 1ns/10ps

module sound_io_tb;
    localparam logic [5:0] base    = 6'h20;
    localparam int         clk_div = 4;
    localparam int         max_cyc = 60000;    // all tests with margin

    logic clk, rst_n, re = 0, we = 0;
    logic [5:0] addr = '0;
    logic [7:0] data_in = '0, data_out, exp_rd = '0;
    logic signal_out;
    logic chk_rd = 0, chk_zero = 0, chk_noise = 0, chk_gate = 0, chk_per = 0, chk_mod = 0;
    logic [7:0] shadow [16];            // register copy, masked
    int exp_a = 0, exp_b = 0, val_err = 0, oth_err = 0, cycles = 0, seed = 72;
    int gap = 0, edges = 0;             // cycles since last edge, edges while armed
    logic last_sig = 1'b0;
    string tname = "reset";
    int unsigned cyc;                   // model clock count after reset
    logic [12:0] n_cnt, l_cnt, n_lim, l_lim;
    logic [11:0] n_freq;
    logic [9:0]  l_freq;
    logic [14:0] n_lfsr;
    logic l_out, noise_d, lfo_d, m_tick;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    sound_io_top #(.base_addr(base), .clk_div(clk_div)) u_dut (
        .clk(clk), .rst_n(rst_n), .addr(addr), .data_out(data_out), .data_in(data_in),
        .re(re), .we(we), .signal_out(signal_out)
    );

    // noise and lfo models, tick every clk_div cycles out of reset
    assign m_tick = (cyc >= clk_div) && ((cyc % clk_div) == 0);
    assign n_lim  = {1'b0, n_freq} + 13'd1;
    assign l_lim  = {3'b0, l_freq} + 13'd1;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= 0;
            {n_cnt, l_cnt, n_freq, l_freq} <= '0;
            n_lfsr <= sound_gen_pkg::lfsr_seed;
            {l_out, noise_d, lfo_d} <= '0;
        end else begin
            cyc    <= cyc + 1;
            n_freq <= {shadow[5][3:0], shadow[4]};     // one cycle behind the bus
            l_freq <= {shadow[7][1:0], shadow[6]};
            if (n_cnt >= n_lim || (m_tick && n_cnt + 13'd1 >= n_lim)) begin
                n_cnt  <= '0;
                n_lfsr <= {n_lfsr[13:0], n_lfsr[sound_gen_pkg::lfsr_tap_a]
                           ^ n_lfsr[sound_gen_pkg::lfsr_tap_b]};
            end else if (m_tick) begin
                n_cnt <= n_cnt + 13'd1;
            end
            if (l_cnt >= l_lim || (m_tick && l_cnt + 13'd1 >= l_lim)) begin
                l_cnt <= '0;
                l_out <= ~l_out;
            end else if (m_tick) begin
                l_cnt <= l_cnt + 13'd1;
            end
            noise_d <= n_lfsr[0];               // mixer register delay
            lfo_d   <= l_out;
        end
    end

    // edge spacing on signal_out
    always @(posedge clk) begin
        last_sig <= signal_out;
        if (signal_out != last_sig) begin
            gap <= 1;
            if (chk_per || chk_mod) edges <= edges + 1;
        end else begin
            gap <= gap + 1;
        end
        if (!(chk_per || chk_mod)) edges <= 0;
    end

    a_read: assert property (@(posedge clk) chk_rd |-> data_out == exp_rd)
        else begin
            val_err++;
            $display("[ERROR] %s expected %0h actual %0h", tname, $sampled(exp_rd),
                     $sampled(data_out));
        end
    a_quiet: assert property (@(posedge clk) chk_zero |-> !signal_out)
        else begin
            val_err++;
            $display("[ERROR] %s expected 0 actual 1", tname);
        end
    a_noise: assert property (@(posedge clk) chk_noise |-> signal_out == noise_d)
        else begin
            val_err++;
            $display("[ERROR] %s expected %0d actual %0d", tname, $sampled(noise_d),
                     $sampled(signal_out));
        end
    a_gate: assert property (@(posedge clk) chk_gate && !lfo_d |-> !signal_out)
        else begin
            val_err++;
            $display("[ERROR] %s expected 0 actual 1", tname);
        end
    a_period: assert property (@(posedge clk)
            chk_per && edges >= 2 && signal_out != last_sig |-> gap == exp_a)
        else begin
            val_err++;
            $display("[ERROR] %s expected %0d actual %0d", tname, exp_a, $sampled(gap));
        end
    a_mod_period: assert property (@(posedge clk)
            chk_mod && edges >= 2 && signal_out != last_sig |-> gap == exp_a || gap == exp_b)
        else begin
            val_err++;
            $display("[ERROR] %s expected %0d or %0d actual %0d", tname, exp_a, exp_b,
                     $sampled(gap));
        end

    // used bits of each register
    function automatic logic [7:0] field_mask(input logic [3:0] off);
        case (off)
            sound_regs_pkg::reg_vco1_hi, sound_regs_pkg::reg_vco2_hi,
            sound_regs_pkg::reg_noise_hi:   return 8'((1 << (sound_regs_pkg::freq_w - 8)) - 1);
            sound_regs_pkg::reg_lfo_hi:     return 8'((1 << (sound_regs_pkg::lfo_freq_w - 8)) - 1);
            sound_regs_pkg::reg_lfo_shift:  return 8'((1 << sound_regs_pkg::shift_w) - 1);
            sound_regs_pkg::reg_mod_select: return 8'((1 << sound_regs_pkg::mod_w) - 1);
            sound_regs_pkg::reg_mixer:      return 8'((1 << sound_regs_pkg::mix_w) - 1);
            default:                        return (off <= 4'd7) ? 8'hff : 8'h00;
        endcase
    endfunction

    task automatic bus_write(input logic [3:0] off, input logic [7:0] d);
        @(posedge clk);
        addr          <= {base[5:4], off};
        data_in       <= d;
        we            <= 1'b1;
        shadow[off]   <= d & field_mask(off);
        @(posedge clk);
        we <= 1'b0;
    endtask

    task automatic read_check(input logic [5:0] a, input logic r, input logic [7:0] e);
        @(posedge clk);
        addr   <= a;
        re     <= r;
        exp_rd <= e;
        chk_rd <= 1'b1;
        @(posedge clk);
        re     <= 1'b0;
        chk_rd <= 1'b0;
    endtask

    // arms one interval check and waits for enough edges
    task automatic tone_period(input logic [3:0] lo_off, input logic [7:0] mix, input string nm);
        int f;
        f = $random(seed) & 31;
        bus_write(sound_regs_pkg::reg_mod_select, 8'h00);
        bus_write(lo_off, 8'(f));
        bus_write(lo_off + 4'd1, 8'h00);
        bus_write(sound_regs_pkg::reg_mixer, mix);
        @(posedge clk);
        tname   <= nm;
        exp_a   <= (f + 1) * clk_div;
        chk_per <= 1'b1;
        while (edges < 8) @(posedge clk);
        chk_per <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cyc) begin
            oth_err++;
            $display("timeout: the run did not finish within %0d cycles", max_cyc);
            $display("errors: %0d wrong values, %0d other", val_err, oth_err);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int d, f;
        for (int i = 0; i < 16; i++) shadow[i] = 8'h00;
        @(posedge rst_n);
        chk_zero <= 1'b1;                       // silent out of reset
        for (int i = 0; i <= 10; i++) read_check({base[5:4], 4'(i)}, 1'b1, 8'h00);
        chk_zero <= 1'b0;
        tname <= "noise";
        bus_write(sound_regs_pkg::reg_noise_lo, 8'(($random(seed) & 7) + 1));
        bus_write(sound_regs_pkg::reg_mixer, 8'h04);
        repeat (4) @(posedge clk);
        chk_noise <= 1'b1;
        repeat (1500) @(posedge clk);
        chk_noise <= 1'b0;
        tname <= "lfo_gate";
        bus_write(sound_regs_pkg::reg_lfo_lo, 8'h03);
        bus_write(sound_regs_pkg::reg_vco1_lo, 8'h01);
        bus_write(sound_regs_pkg::reg_mixer, 8'h09);
        repeat (4) @(posedge clk);
        chk_gate <= 1'b1;
        repeat (2000) @(posedge clk);
        chk_gate <= 1'b0;
        tname <= "readback";
        for (int i = 0; i <= 10; i++) begin
            d = $random(seed);
            bus_write(4'(i), 8'(d));
            read_check({base[5:4], 4'(i)}, 1'b1, 8'(d) & field_mask(4'(i)));
        end
        for (int i = 11; i <= 15; i++) read_check({base[5:4], 4'(i)}, 1'b1, 8'h00);
        for (int i = 0; i <= 10; i++) read_check({2'b01, 4'(i)}, 1'b1, 8'h00);
        for (int i = 0; i <= 10; i++) read_check({base[5:4], 4'(i)}, 1'b0, 8'h00);
        tone_period(sound_regs_pkg::reg_vco1_lo, 8'h01, "vco1_period");
        tone_period(sound_regs_pkg::reg_vco2_lo, 8'h02, "vco2_period");
        tname <= "mixer_off";
        bus_write(sound_regs_pkg::reg_mixer, 8'h00);
        repeat (2) @(posedge clk);
        chk_zero <= 1'b1;
        repeat (300) @(posedge clk);
        chk_zero <= 1'b0;
        f = ($random(seed) & 31) | 8;           // big enough for a visible stretch
        bus_write(sound_regs_pkg::reg_lfo_lo, 8'h05);
        bus_write(sound_regs_pkg::reg_lfo_hi, 8'h00);
        bus_write(sound_regs_pkg::reg_lfo_shift, 8'h01);
        bus_write(sound_regs_pkg::reg_vco1_lo, 8'(f));
        bus_write(sound_regs_pkg::reg_vco1_hi, 8'h00);
        bus_write(sound_regs_pkg::reg_mod_select, 8'h01);
        bus_write(sound_regs_pkg::reg_mixer, 8'h01);
        @(posedge clk);
        tname   <= "vco1_mod";
        exp_a   <= (f + 1) * clk_div;
        exp_b   <= (f + 1 + (f >> 1)) * clk_div;
        chk_mod <= 1'b1;
        while (edges < 20) @(posedge clk);
        chk_mod <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d wrong values, %0d other", val_err, oth_err);
        if (val_err == 0 && oth_err == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int half_period = 20,     // 40 ns clock
    parameter int rst_cycles  = 8
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;    // release away from the active edge
    end

endmodule

// File: design/sound_io_top.sv
`timescale 1ns/10ps

module sound_io_top #(
    parameter logic [sound_regs_pkg::addr_w-1:0] base_addr = '0,
    parameter int unsigned                       clk_div   = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [sound_regs_pkg::addr_w-1:0] addr,
    output logic [sound_regs_pkg::data_w-1:0] data_out,
    input  logic [sound_regs_pkg::data_w-1:0] data_in,
    input  logic                              re,
    input  logic                              we,
    output logic                              signal_out     // one-bit sound
);
    logic [sound_regs_pkg::freq_w-1:0]     vco1_freq;
    logic [sound_regs_pkg::freq_w-1:0]     vco2_freq;
    logic [sound_regs_pkg::freq_w-1:0]     noise_freq;
    logic [sound_regs_pkg::lfo_freq_w-1:0] lfo_freq;
    logic [sound_regs_pkg::shift_w-1:0]    lfo_shift;
    logic [sound_regs_pkg::mod_w-1:0]      mod_select;
    logic [sound_regs_pkg::mix_w-1:0]      mixer;
    logic                                  tick;          // from the mixer divider
    logic                                  vco1_out;
    logic                                  vco2_out;
    logic                                  noise_out;
    logic                                  lfo_out;

    sound_io_regs #(.base_addr(base_addr)) u_regs (
        .clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .re(re), .we(we),
        .data_out(data_out), .vco1_freq(vco1_freq), .vco2_freq(vco2_freq),
        .noise_freq(noise_freq), .lfo_freq(lfo_freq), .lfo_shift(lfo_shift),
        .mod_select(mod_select), .mixer(mixer)
    );

    tone_osc u_vco1 (
        .clk(clk), .rst_n(rst_n), .tick(tick), .freq(vco1_freq), .lfo_out(lfo_out),
        .mod_en(mod_select[sound_gen_pkg::mod_vco1]), .lfo_shift(lfo_shift),
        .tone_out(vco1_out)
    );

    tone_osc u_vco2 (
        .clk(clk), .rst_n(rst_n), .tick(tick), .freq(vco2_freq), .lfo_out(lfo_out),
        .mod_en(mod_select[sound_gen_pkg::mod_vco2]), .lfo_shift(lfo_shift),
        .tone_out(vco2_out)
    );

    // lfo is never modulated, rate word zero-extended
    tone_osc u_lfo (
        .clk(clk), .rst_n(rst_n), .tick(tick),
        .freq({{(sound_regs_pkg::freq_w - sound_regs_pkg::lfo_freq_w){1'b0}}, lfo_freq}),
        .lfo_out(1'b0), .mod_en(1'b0), .lfo_shift(lfo_shift), .tone_out(lfo_out)
    );

    noise_gen u_noise (
        .clk(clk), .rst_n(rst_n), .tick(tick), .freq(noise_freq), .lfo_out(lfo_out),
        .mod_en(mod_select[sound_gen_pkg::mod_noise]), .lfo_shift(lfo_shift),
        .noise_out(noise_out)
    );

    sound_mixer #(.clk_div(clk_div)) u_mixer (
        .clk(clk), .rst_n(rst_n), .vco1_out(vco1_out), .vco2_out(vco2_out),
        .noise_out(noise_out), .lfo_out(lfo_out), .mixer(mixer), .tick(tick),
        .signal_out(signal_out)
    );

endmodule

// File: design/sound_mixer.sv
`timescale 1ns/10ps

module sound_mixer #(
    parameter int unsigned clk_div = 4      // clocks per sound tick, 1 or more
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             vco1_out,
    input  logic                             vco2_out,
    input  logic                             noise_out,
    input  logic                             lfo_out,
    input  logic [sound_regs_pkg::mix_w-1:0] mixer,    // source enables
    output logic                             tick,     // one clk wide, every clk_div
    output logic                             signal_out
);
    localparam int cw = $clog2(clk_div + 1);            // at least one bit

    logic [cw-1:0]                    div_cnt;
    logic [sound_regs_pkg::mix_w-1:0] src;              // sources in mixer bit order
    logic                             mix_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == cw'(clk_div - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;                            // first one clk_div clocks out of reset
        end else begin
            div_cnt <= div_cnt + cw'(1);
            tick    <= 1'b0;
        end
    end

    assign src[sound_gen_pkg::mix_vco1]  = vco1_out;
    assign src[sound_gen_pkg::mix_vco2]  = vco2_out;
    assign src[sound_gen_pkg::mix_noise] = noise_out;
    assign src[sound_gen_pkg::mix_lfo]   = lfo_out;

    // disabled sources read as 1 in the and, silent when none enabled
    assign mix_d = (|mixer) & (&(src | ~mixer));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            signal_out <= 1'b0;
        end else begin
            signal_out <= mix_d;                        // one clk behind the sources
        end
    end

endmodule

// File: design/noise_gen.sv
`timescale 1ns/10ps

module noise_gen (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               tick,
    input  logic [sound_regs_pkg::freq_w-1:0]  freq,        // shift every freq+1 ticks
    input  logic                               lfo_out,
    input  logic                               mod_en,
    input  logic [sound_regs_pkg::shift_w-1:0] lfo_shift,
    output logic                               noise_out
);
    localparam int lw = sound_regs_pkg::freq_w + 1;
    localparam int nw = sound_gen_pkg::lfsr_w;

    logic [lw-1:0] cnt;
    logic [lw-1:0] limit;
    logic          mod_q;       // modulation for the running interval
    logic          reach;
    logic          over;
    logic [nw-1:0] lfsr;        // fibonacci, shifts left
    logic          fb;

    // same rate rule as the tone oscillators
    assign limit = lw'(freq) + lw'(1) + (mod_q ? lw'(freq >> lfo_shift) : '0);
    assign reach = tick && ((cnt + lw'(1)) >= limit);
    assign over  = (cnt >= limit);

    assign fb        = lfsr[sound_gen_pkg::lfsr_tap_a] ^ lfsr[sound_gen_pkg::lfsr_tap_b];
    assign noise_out = lfsr[0];                         // newest bit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            mod_q <= 1'b0;
            lfsr  <= sound_gen_pkg::lfsr_seed;
        end else if (reach || over) begin
            cnt   <= '0;
            mod_q <= mod_en & lfo_out;
            lfsr  <= {lfsr[nw-2:0], fb};                // one step per reload
        end else if (tick) begin
            cnt <= cnt + lw'(1);
        end
    end

    // a zero lfsr would lock the noise at a constant level
    a_lfsr_live: assert property (@(posedge clk) disable iff (!rst_n) lfsr != '0)
        else $error("noise lfsr reached the all-zero state");

endmodule

// File: design/tone_osc.sv
`timescale 1ns/10ps

module tone_osc (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               tick,        // sound engine step
    input  logic [sound_regs_pkg::freq_w-1:0]  freq,        // half period is freq+1 ticks
    input  logic                               lfo_out,
    input  logic                               mod_en,      // lfo stretches this osc
    input  logic [sound_regs_pkg::shift_w-1:0] lfo_shift,   // depth, freq >> shift added
    output logic                               tone_out
);
    localparam int lw = sound_regs_pkg::freq_w + 1;     // fits 2*freq+1

    logic [lw-1:0] cnt;         // ticks into this half period
    logic [lw-1:0] limit;
    logic          mod_q;       // lfo state caught at the last reload
    logic          reach;       // half period done on this tick
    logic          over;        // rate word shrank under the count

    // modulation holds for a whole half period, rate word is live
    assign limit = lw'(freq) + lw'(1) + (mod_q ? lw'(freq >> lfo_shift) : '0);

    assign reach = tick && ((cnt + lw'(1)) >= limit);
    assign over  = (cnt >= limit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            mod_q    <= 1'b0;
            tone_out <= 1'b0;
        end else if (reach || over) begin
            cnt      <= '0;                 // reload
            mod_q    <= mod_en & lfo_out;
            tone_out <= ~tone_out;          // square wave edge
        end else if (tick) begin
            cnt <= cnt + lw'(1);
        end
    end

    // count only passes its limit in the cycle after the limit moved
    a_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
            over |-> limit != $past(limit))
        else $error("tone counter above its limit with no rate change");

endmodule

// File: design/sound_io_regs.sv
`timescale 1ns/10ps

module sound_io_regs #(
    parameter logic [sound_regs_pkg::addr_w-1:0] base_addr = '0   // only bits 5:4 compared
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [sound_regs_pkg::addr_w-1:0]     addr,
    input  logic [sound_regs_pkg::data_w-1:0]     data_in,
    input  logic                                  re,
    input  logic                                  we,
    output logic [sound_regs_pkg::data_w-1:0]     data_out,     // combinational read-back
    output logic [sound_regs_pkg::freq_w-1:0]     vco1_freq,
    output logic [sound_regs_pkg::freq_w-1:0]     vco2_freq,
    output logic [sound_regs_pkg::freq_w-1:0]     noise_freq,
    output logic [sound_regs_pkg::lfo_freq_w-1:0] lfo_freq,
    output logic [sound_regs_pkg::shift_w-1:0]    lfo_shift,
    output logic [sound_regs_pkg::mod_w-1:0]      mod_select,
    output logic [sound_regs_pkg::mix_w-1:0]      mixer
);
    localparam int aw = sound_regs_pkg::addr_w;
    localparam int dw = sound_regs_pkg::data_w;
    localparam int fw = sound_regs_pkg::freq_w;
    localparam int lw = sound_regs_pkg::lfo_freq_w;

    logic       base_hit;   // upper address bits select this block
    logic [3:0] offset;     // register within the block

    // one decode, shared by write and read
    assign base_hit = (addr[aw-1:aw-2] == base_addr[aw-1:aw-2]);
    assign offset   = addr[aw-3:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vco1_freq  <= sound_regs_pkg::freq_rst;
            vco2_freq  <= sound_regs_pkg::freq_rst;
            noise_freq <= sound_regs_pkg::freq_rst;
            lfo_freq   <= sound_regs_pkg::lfo_freq_rst;
            lfo_shift  <= sound_regs_pkg::shift_rst;
            mod_select <= sound_regs_pkg::mod_rst;
            mixer      <= sound_regs_pkg::mix_rst;
        end else if (we && base_hit) begin
            case (offset)
                sound_regs_pkg::reg_vco1_lo:    vco1_freq[dw-1:0]   <= data_in;
                sound_regs_pkg::reg_vco1_hi:    vco1_freq[fw-1:dw]  <= data_in[fw-dw-1:0];
                sound_regs_pkg::reg_vco2_lo:    vco2_freq[dw-1:0]   <= data_in;
                sound_regs_pkg::reg_vco2_hi:    vco2_freq[fw-1:dw]  <= data_in[fw-dw-1:0];
                sound_regs_pkg::reg_noise_lo:   noise_freq[dw-1:0]  <= data_in;
                sound_regs_pkg::reg_noise_hi:   noise_freq[fw-1:dw] <= data_in[fw-dw-1:0];
                sound_regs_pkg::reg_lfo_lo:     lfo_freq[dw-1:0]    <= data_in;
                sound_regs_pkg::reg_lfo_hi:     lfo_freq[lw-1:dw]   <= data_in[lw-dw-1:0];
                sound_regs_pkg::reg_lfo_shift:
                    lfo_shift  <= data_in[sound_regs_pkg::shift_w-1:0];
                sound_regs_pkg::reg_mod_select:
                    mod_select <= data_in[sound_regs_pkg::mod_w-1:0];
                sound_regs_pkg::reg_mixer:
                    mixer      <= data_in[sound_regs_pkg::mix_w-1:0];
                default: ;                              // 11..15 unmapped, write dropped
            endcase
        end
    end

    always_comb begin
        data_out = '0;                                  // idle bus reads as zero
        if (re && base_hit) begin
            case (offset)
                sound_regs_pkg::reg_vco1_lo:    data_out = vco1_freq[dw-1:0];
                sound_regs_pkg::reg_vco1_hi:    data_out = dw'(vco1_freq[fw-1:dw]);
                sound_regs_pkg::reg_vco2_lo:    data_out = vco2_freq[dw-1:0];
                sound_regs_pkg::reg_vco2_hi:    data_out = dw'(vco2_freq[fw-1:dw]);
                sound_regs_pkg::reg_noise_lo:   data_out = noise_freq[dw-1:0];
                sound_regs_pkg::reg_noise_hi:   data_out = dw'(noise_freq[fw-1:dw]);
                sound_regs_pkg::reg_lfo_lo:     data_out = lfo_freq[dw-1:0];
                sound_regs_pkg::reg_lfo_hi:     data_out = dw'(lfo_freq[lw-1:dw]);
                sound_regs_pkg::reg_lfo_shift:  data_out = dw'(lfo_shift);
                sound_regs_pkg::reg_mod_select: data_out = dw'(mod_select);
                sound_regs_pkg::reg_mixer:      data_out = dw'(mixer);
                default:                        data_out = '0;   // unmapped
            endcase
        end
    end

    // cpu never reads and writes in the same cycle
    a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rst_n) !(re && we))
        else $error("re and we high in the same cycle");

endmodule

// File: design/sound_gen_pkg.sv
package sound_gen_pkg;

    // noise lfsr
    localparam int lfsr_w = 15;                             // noise shift register width
    localparam logic [lfsr_w-1:0] lfsr_seed = 15'h5a3c;     // any nonzero start value
    localparam int lfsr_tap_a = 14;                         // feedback taps, xored
    localparam int lfsr_tap_b = 13;

    // source bits in the mixer enable word
    localparam int mix_vco1  = 0;
    localparam int mix_vco2  = 1;
    localparam int mix_noise = 2;
    localparam int mix_lfo   = 3;

    // source bits in the modulation select word
    localparam int mod_vco1  = 0;
    localparam int mod_vco2  = 1;
    localparam int mod_noise = 2;

endpackage

// File: design/sound_regs_pkg.sv
package sound_regs_pkg;

    // bus words
    localparam int addr_w = 6;          // io port address, bits 5:4 pick the block
    localparam int data_w = 8;          // byte-wide data bus

    // register offsets, matched against addr[3:0]
    localparam logic [3:0] reg_vco1_lo    = 4'h0;
    localparam logic [3:0] reg_vco1_hi    = 4'h1;
    localparam logic [3:0] reg_vco2_lo    = 4'h2;
    localparam logic [3:0] reg_vco2_hi    = 4'h3;
    localparam logic [3:0] reg_noise_lo   = 4'h4;
    localparam logic [3:0] reg_noise_hi   = 4'h5;
    localparam logic [3:0] reg_lfo_lo     = 4'h6;
    localparam logic [3:0] reg_lfo_hi     = 4'h7;
    localparam logic [3:0] reg_lfo_shift  = 4'h8;   // modulation depth
    localparam logic [3:0] reg_mod_select = 4'h9;   // {noise, vco2, vco1}
    localparam logic [3:0] reg_mixer      = 4'ha;   // {lfo, noise, vco2, vco1}

    // field widths
    localparam int freq_w     = 12;     // vco1, vco2, noise rate words
    localparam int lfo_freq_w = 10;     // lfo rate word
    localparam int shift_w    = 3;
    localparam int mod_w      = 3;
    localparam int mix_w      = 4;

    // values after reset
    localparam logic [freq_w-1:0]     freq_rst     = '0;
    localparam logic [lfo_freq_w-1:0] lfo_freq_rst = '0;
    localparam logic [shift_w-1:0]    shift_rst    = '0;
    localparam logic [mod_w-1:0]      mod_rst      = '0;   // nothing modulated
    localparam logic [mix_w-1:0]      mix_rst      = '0;   // output silent

endpackage
